//--- compile.f
hdl/bus_pkg.sv
hdl/periph_pkg.sv
hdl/periph_bus_if.sv
hdl/bus_decoder.sv
hdl/timer.sv
hdl/irq_ctrl.sv
hdl/periph_top.sv
tb/tb_clock_gen.sv
tb/periph_assertions.sv
tb/periph_checker.sv
tb/periph_tb.sv

//--- hdl/bus_decoder.sv
// address decoder that routes bus requests to the slots and muxes the responses
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       req_i,
    input  logic                       we_i,
    input  logic [bus_pkg::ADDR_W-1:0] addr_i,
    input  logic [bus_pkg::DATA_W-1:0] wdata_i,
    output logic [bus_pkg::DATA_W-1:0] rdata_o,
    output logic                       ack_o,
    periph_bus_if.master               tmr0_bus,
    periph_bus_if.master               tmr1_bus,
    periph_bus_if.master               irq_bus
);
    import bus_pkg::*;

    logic [SLOT_W-1:0] slot;
    logic [SLOT_W-1:0] slot_q;
    logic              slot_mapped;
    logic              unmapped_ack_q;

    // slot field of the current request
    assign slot        = addr_i[SLOT_MSB:SLOT_LSB];
    assign slot_mapped = (slot == SLOT_TIMER0) || (slot == SLOT_TIMER1) || (slot == SLOT_IRQ);

    // strobe only the addressed slave
    assign tmr0_bus.req = req_i && (slot == SLOT_TIMER0);
    assign tmr1_bus.req = req_i && (slot == SLOT_TIMER1);
    assign irq_bus.req  = req_i && (slot == SLOT_IRQ);

    // request fields go to every slave unchanged
    assign tmr0_bus.we    = we_i;
    assign tmr0_bus.addr  = addr_i;
    assign tmr0_bus.wdata = wdata_i;

    assign tmr1_bus.we    = we_i;
    assign tmr1_bus.addr  = addr_i;
    assign tmr1_bus.wdata = wdata_i;

    assign irq_bus.we     = we_i;
    assign irq_bus.addr   = addr_i;
    assign irq_bus.wdata  = wdata_i;

    // slot of last cycle selects this cycle's response
    // idle cycles are harmless since no slave acks without a request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_q         <= '0;
            unmapped_ack_q <= 1'b0;
        end else begin
            slot_q         <= slot;
            // nobody else answers an unmapped slot
            unmapped_ack_q <= req_i && !slot_mapped;
        end
    end

    // response mux
    always_comb begin
        case (slot_q)
            SLOT_TIMER0: begin
                rdata_o = tmr0_bus.rdata;
                ack_o   = tmr0_bus.ack;
            end
            SLOT_TIMER1: begin
                rdata_o = tmr1_bus.rdata;
                ack_o   = tmr1_bus.ack;
            end
            SLOT_IRQ: begin
                rdata_o = irq_bus.rdata;
                ack_o   = irq_bus.ack;
            end
            default: begin
                // unmapped slot reads as zero
                rdata_o = '0;
                ack_o   = unmapped_ack_q;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/bus_pkg.sv
// bus widths, slot address map and register offset field of the peripheral bus
`default_nettype none

package bus_pkg;

    // word wide data path
    localparam int DATA_W = 32;

    // full byte address from the processor
    localparam int ADDR_W = 32;

    // address bits that pick a slave slot
    localparam int SLOT_LSB = 12;
    localparam int SLOT_MSB = 15;
    localparam int SLOT_W   = SLOT_MSB - SLOT_LSB + 1;

    // mapped slots
    // any other slot value is answered by the decoder with zero data
    localparam logic [SLOT_W-1:0] SLOT_TIMER0 = 'd0;
    localparam logic [SLOT_W-1:0] SLOT_TIMER1 = 'd1;
    localparam logic [SLOT_W-1:0] SLOT_IRQ    = 'd2;

    // register offset inside a slot, taken from the low address bits
    localparam int OFFS_W = 4;

endpackage

`default_nettype wire

//--- hdl/irq_ctrl.sv
// interrupt controller that masks the timer lines and merges them into one irq
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    periph_bus_if.slave                   bus,
    input  logic [periph_pkg::NUM_IRQ-1:0] irq_src_i,
    output logic                          irq_o
);
    import bus_pkg::*;
    import periph_pkg::*;

    logic [NUM_IRQ-1:0] status_q;
    logic [NUM_IRQ-1:0] mask_q;
    logic [DATA_W-1:0]  rdata_q;
    logic               ack_q;
    logic [DATA_W-1:0]  rd_mux;
    logic [OFFS_W-1:0]  offs;
    logic               wr_mask;

    assign offs    = bus.addr[OFFS_W-1:0];
    assign wr_mask = bus.req && bus.we && (offs == IRQ_REG_MASK);

    // status tracks the raw source levels
    // read only, writes to it are dropped
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status_q <= '0;
        end else begin
            status_q <= irq_src_i;
        end
    end

    // mask, one enable bit per source
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mask_q <= '0;
        end else if (wr_mask) begin
            mask_q <= bus.wdata[NUM_IRQ-1:0];
        end
    end

    // any unmasked source raises the processor interrupt
    assign irq_o = |(status_q & mask_q);

    // upper bits read as zero
    always_comb begin
        case (offs)
            IRQ_REG_STATUS: rd_mux = {{(DATA_W-NUM_IRQ){1'b0}}, status_q};
            IRQ_REG_MASK:   rd_mux = {{(DATA_W-NUM_IRQ){1'b0}}, mask_q};
            default:        rd_mux = '0;
        endcase
    end

    // response one cycle after the request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata_q <= '0;
            ack_q   <= 1'b0;
        end else begin
            rdata_q <= (bus.req && !bus.we) ? rd_mux : '0;
            ack_q   <= bus.req;
        end
    end

    assign bus.rdata = rdata_q;
    assign bus.ack   = ack_q;

endmodule

`default_nettype wire

//--- hdl/periph_bus_if.sv
// request and response bus between the address decoder and one slave
`timescale 1ns/1ps
`default_nettype none

interface periph_bus_if;
    import bus_pkg::*;

    // request side, single cycle strobe
    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;

    // response side, one cycle after req
    logic [DATA_W-1:0] rdata;
    logic              ack;

    // decoder end
    modport master (
        output req, we, addr, wdata,
        input  rdata, ack
    );

    // timer or irq controller end
    modport slave (
        input  req, we, addr, wdata,
        output rdata, ack
    );

endinterface

`default_nettype wire

//--- hdl/periph_pkg.sv
// register offsets and control bits of the timers and the interrupt controller
`default_nettype none

package periph_pkg;

    // timer register offsets
    localparam logic [bus_pkg::OFFS_W-1:0] TMR_REG_CTRL  = 'h0;
    localparam logic [bus_pkg::OFFS_W-1:0] TMR_REG_COUNT = 'h4;
    localparam logic [bus_pkg::OFFS_W-1:0] TMR_REG_VALUE = 'h8;

    // timer control bits
    // run enable, cleared by hardware on expiry
    localparam int CTRL_EN     = 0;
    // interrupt enable towards the interrupt controller
    localparam int CTRL_INT_EN = 1;
    // expiry flag, write 1 to clear
    localparam int CTRL_PEND   = 2;

    // interrupt controller register offsets
    localparam logic [bus_pkg::OFFS_W-1:0] IRQ_REG_STATUS = 'h0;
    localparam logic [bus_pkg::OFFS_W-1:0] IRQ_REG_MASK   = 'h4;

    // one source per timer
    localparam int NUM_IRQ = 2;

endpackage

`default_nettype wire

//--- hdl/periph_top.sv
// peripheral block top with the decoder, two timers and the interrupt controller
`timescale 1ns/1ps
`default_nettype none

module periph_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       req_i,
    input  logic                       we_i,
    input  logic [bus_pkg::ADDR_W-1:0] addr_i,
    input  logic [bus_pkg::DATA_W-1:0] wdata_i,
    output logic [bus_pkg::DATA_W-1:0] rdata_o,
    output logic                       ack_o,
    output logic                       irq_o
);
    import periph_pkg::*;

    // raw timer interrupt levels
    // bit 0 is timer0, bit 1 is timer1
    logic [NUM_IRQ-1:0] irq_src;

    // one bus per slot
    periph_bus_if tmr0_if ();
    periph_bus_if tmr1_if ();
    periph_bus_if irq_if ();

    bus_decoder bus_decoder_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_i    (req_i),
        .we_i     (we_i),
        .addr_i   (addr_i),
        .wdata_i  (wdata_i),
        .rdata_o  (rdata_o),
        .ack_o    (ack_o),
        .tmr0_bus (tmr0_if.master),
        .tmr1_bus (tmr1_if.master),
        .irq_bus  (irq_if.master)
    );

    timer timer0 (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (tmr0_if.slave),
        .int_o (irq_src[0])
    );

    timer timer1 (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (tmr1_if.slave),
        .int_o (irq_src[1])
    );

    irq_ctrl irq_ctrl_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (irq_if.slave),
        .irq_src_i (irq_src),
        .irq_o     (irq_o)
    );

endmodule

`default_nettype wire

//--- hdl/timer.sv
// 32-bit up-counting timer with compare value, enable and pending interrupt flag
`timescale 1ns/1ps
`default_nettype none

module timer (
    input  logic        clk,
    input  logic        rst_n,
    periph_bus_if.slave bus,
    output logic        int_o
);
    import bus_pkg::*;
    import periph_pkg::*;

    logic [DATA_W-1:0] ctrl_q;
    logic [DATA_W-1:0] count_q;
    logic [DATA_W-1:0] value_q;
    logic [DATA_W-1:0] rdata_q;
    logic              ack_q;
    logic [DATA_W-1:0] rd_mux;
    logic [OFFS_W-1:0] offs;
    logic              wr_ctrl;
    logic              wr_value;
    logic              expire;

    assign offs     = bus.addr[OFFS_W-1:0];
    assign wr_ctrl  = bus.req && bus.we && (offs == TMR_REG_CTRL);
    assign wr_value = bus.req && bus.we && (offs == TMR_REG_VALUE);

    // count has reached compare while running
    // independent of any bus activity
    assign expire = ctrl_q[CTRL_EN] && (count_q == value_q);

    // level interrupt, held until software clears pending
    assign int_o = ctrl_q[CTRL_PEND] && ctrl_q[CTRL_INT_EN];

    // control register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl_q <= '0;
        end else begin
            if (wr_ctrl) begin
                // spare bits are stored as written
                ctrl_q <= bus.wdata;
                // pending only drops on a written 1
                ctrl_q[CTRL_PEND] <= ctrl_q[CTRL_PEND] && !bus.wdata[CTRL_PEND];
            end
            // expiry wins over a concurrent write
            if (expire) begin
                ctrl_q[CTRL_EN]   <= 1'b0;
                ctrl_q[CTRL_PEND] <= 1'b1;
            end
        end
    end

    // counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (!ctrl_q[CTRL_EN] || expire) begin
            // parked at zero while stopped
            count_q <= '0;
        end else begin
            count_q <= count_q + 1'b1;
        end
    end

    // compare value
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            value_q <= '0;
        end else if (wr_value) begin
            value_q <= bus.wdata;
        end
    end

    // read select, count offset is read only
    always_comb begin
        case (offs)
            TMR_REG_CTRL:  rd_mux = ctrl_q;
            TMR_REG_COUNT: rd_mux = count_q;
            TMR_REG_VALUE: rd_mux = value_q;
            default:       rd_mux = '0;
        endcase
    end

    // registered response, one cycle after the request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata_q <= '0;
            ack_q   <= 1'b0;
        end else begin
            rdata_q <= (bus.req && !bus.we) ? rd_mux : '0;
            ack_q   <= bus.req;
        end
    end

    assign bus.rdata = rdata_q;
    assign bus.ack   = ack_q;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# builds the peripheral testbench with Verilator, runs it and scans the log
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f compile.f --top-module periph_tb -o periph_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/periph_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$log"; then
    exit 1
fi
exit 0

//--- tb/periph_assertions.sv
// concurrent checks of bus timing and reset behaviour at the address decoder
`timescale 1ns/1ps
`default_nettype none

module periph_assertions (
    input logic clk,
    input logic rst_n,
    input logic req_i,
    input logic ack_i
);

    // each request answered on the following cycle
    ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n) req_i |=> ack_i)
        else $error("request at %0t got no ack one cycle later", $time);

    // back to back acks only after back to back requests
    ack_pair_needs_reqs: assert property (@(posedge clk) disable iff (!rst_n)
        ack_i && $past(ack_i) |-> $past(req_i) && $past(req_i, 2))
        else $error("ack at %0t held for two cycles without two requests", $time);

    // nothing acknowledged while in reset
    no_ack_in_reset: assert property (@(posedge clk) !rst_n |=> !ack_i)
        else $error("ack raised at %0t during reset", $time);

endmodule

`default_nettype wire

//--- tb/periph_checker.sv
// response checker that compares read data and irq level with expected values
`timescale 1ns/1ps
`default_nettype none

module periph_checker (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       req_i,
    input  logic                       ack_i,
    input  logic [bus_pkg::DATA_W-1:0] rdata_i,
    input  logic                       irq_i,
    input  logic                       chk_rd_i,
    input  logic [bus_pkg::DATA_W-1:0] exp_rd_i,
    input  logic                       chk_irq_i,
    input  logic                       exp_irq_i,
    input  logic                       poll_miss_i,
    output int                         rd_errs_o,
    output int                         irq_errs_o,
    output int                         misc_errs_o
);
    import bus_pkg::*;

    // one entry per accepted request
    // top bit says whether rdata is compared
    logic [DATA_W:0] pend_q[$];
    logic [DATA_W:0] head;

    always @(posedge clk) begin
        if (!rst_n) begin
            pend_q.delete();
        end else begin
            // response to the request taken one cycle earlier
            if (ack_i) begin
                if (pend_q.size() == 0) begin
                    $display("ack at %0t arrived without any request", $time);
                    misc_errs_o = misc_errs_o + 1;
                end else begin
                    head = pend_q.pop_front();
                    if (head[DATA_W] && rdata_i !== head[DATA_W-1:0]) begin
                        $display("Fail at %0t: rdata_o expected %h, got %h",
                                 $time, head[DATA_W-1:0], rdata_i);
                        rd_errs_o = rd_errs_o + 1;
                    end
                end
            end
            if (req_i) begin
                pend_q.push_back({chk_rd_i, exp_rd_i});
            end
            // irq level sampled at the same edge as the flag
            if (chk_irq_i && irq_i !== exp_irq_i) begin
                $display("Fail at %0t: irq_o expected %b, got %b", $time, exp_irq_i, irq_i);
                irq_errs_o = irq_errs_o + 1;
            end
            if (poll_miss_i) begin
                $display("poll ending at %0t ran out of reads, the timer never expired", $time);
                misc_errs_o = misc_errs_o + 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/periph_tb.sv
// testbench top that replays the vector file against the peripheral block
`timescale 1ns/1ps
`default_nettype none

module periph_tb;
    import bus_pkg::*;
    import periph_pkg::*;

    logic              clk;
    logic              rst_n;
    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;
    logic              ack;
    logic              irq;

    // expectations handed to the checker
    logic              chk_rd;
    logic [DATA_W-1:0] exp_rd;
    logic              chk_irq;
    logic              exp_irq;
    logic              poll_miss;
    int                rd_errs;
    int                irq_errs;
    int                misc_errs;
    int                bad_ops;

    // vector columns
    logic [7:0]        op_q[$];
    logic [ADDR_W-1:0] addr_q[$];
    logic [DATA_W-1:0] data_q[$];
    logic [DATA_W-1:0] exp_q[$];

    logic [DATA_W-1:0] rd;
    int                fd;
    int                cycles;
    int                cycle_limit;

    tb_clock_gen tb_clock_gen_i (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    periph_top periph_top_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_i   (req),
        .we_i    (we),
        .addr_i  (addr),
        .wdata_i (wdata),
        .rdata_o (rdata),
        .ack_o   (ack),
        .irq_o   (irq)
    );

    periph_checker periph_checker_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_i       (req),
        .ack_i       (ack),
        .rdata_i     (rdata),
        .irq_i       (irq),
        .chk_rd_i    (chk_rd),
        .exp_rd_i    (exp_rd),
        .chk_irq_i   (chk_irq),
        .exp_irq_i   (exp_irq),
        .poll_miss_i (poll_miss),
        .rd_errs_o   (rd_errs),
        .irq_errs_o  (irq_errs),
        .misc_errs_o (misc_errs)
    );

    bind bus_decoder periph_assertions periph_assertions_i (
        .clk   (clk),
        .rst_n (rst_n),
        .req_i (req_i),
        .ack_i (ack_o)
    );

    // lines starting with # are comments
    task automatic load_vectors(input int vec_fd);
        string       line;
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        int          n;
        while ($fgets(line, vec_fd) != 0) begin
            n = $sscanf(line, "%c %h %h %h", op, a, d, e);
            if (line.getc(0) != "#" && n == 4) begin
                op_q.push_back(op);
                addr_q.push_back(a);
                data_q.push_back(d);
                exp_q.push_back(e);
            end
        end
        $fclose(vec_fd);
    endtask

    // single request, waits for its ack and returns the data seen with it
    task automatic transfer(input logic wr, input logic [ADDR_W-1:0] a,
                            input logic [DATA_W-1:0] d, input logic check,
                            input logic [DATA_W-1:0] e, output logic [DATA_W-1:0] r);
        @(posedge clk);
        req    <= 1'b1;
        we     <= wr;
        addr   <= a;
        wdata  <= d;
        chk_rd <= check;
        exp_rd <= e;
        @(posedge clk);
        req    <= 1'b0;
        chk_rd <= 1'b0;
        // watchdog stops the run if the ack never comes
        do begin
            @(posedge clk);
        end while (ack !== 1'b1);
        r = rdata;
    endtask

    // read again until the expected word shows up, at most 64 reads
    task automatic poll_until(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] e);
        logic [DATA_W-1:0] r;
        int                tries;
        tries = 0;
        r     = ~e;
        while (r !== e && tries < 64) begin
            transfer(1'b0, a, '0, 1'b0, '0, r);
            tries++;
        end
        if (r !== e) begin
            @(posedge clk);
            poll_miss <= 1'b1;
            @(posedge clk);
            poll_miss <= 1'b0;
        end
    endtask

    // checker samples irq_o on the edge after the flag goes up
    task automatic check_irq(input logic level);
        @(posedge clk);
        chk_irq <= 1'b1;
        exp_irq <= level;
        @(posedge clk);
        chk_irq <= 1'b0;
    endtask

    // cycle watchdog
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("cycle limit of %0d reached before the vectors finished", cycle_limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        req         = 1'b0;
        we          = 1'b0;
        addr        = '0;
        wdata       = '0;
        chk_rd      = 1'b0;
        exp_rd      = '0;
        chk_irq     = 1'b0;
        exp_irq     = 1'b0;
        poll_miss   = 1'b0;
        bad_ops     = 0;
        cycles      = 0;
        cycle_limit = 0;
        fd = $fopen("tb/periph_vectors.txt", "r");
        if (fd == 0) begin
            $display("vector file tb/periph_vectors.txt could not be opened");
            $display("FAIL: see errors above");
            $finish;
        end else begin
            load_vectors(fd);
            cycle_limit = op_q.size() * 70;
            wait (rst_n === 1'b1);
            foreach (op_q[i]) begin
                case (op_q[i])
                    "W": transfer(1'b1, addr_q[i], data_q[i], 1'b0, '0, rd);
                    "R": transfer(1'b0, addr_q[i], '0, 1'b1, exp_q[i], rd);
                    "P": poll_until(addr_q[i], exp_q[i]);
                    "I": check_irq(exp_q[i][0]);
                    default: begin
                        $display("vector %0d has an unknown operation", i);
                        bad_ops++;
                    end
                endcase
            end
            // let the last response reach the checker
            repeat (3) @(posedge clk);
            $display("errors: %0d read data, %0d irq level, %0d other",
                     rd_errs, irq_errs, misc_errs + bad_ops);
            if (rd_errs + irq_errs + misc_errs + bad_ops == 0) begin
                $display("PASS: all tests");
            end else begin
                $display("FAIL: see errors above");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tb/periph_vectors.txt
# op addr wdata expected (hex); W write, R read and compare, P poll, I irq_o level
# slots: timer0 at 0000, timer1 at 1000, irq controller at 2000
W 00000008 0000000a 00000000
R 00000008 00000000 0000000a
W 00001008 00000003 00000000
R 00001008 00000000 00000003
W 00002004 00000003 00000000
R 00002004 00000000 00000003
W 00000000 000000f2 00000000
R 00000000 00000000 000000f2
W 00000004 12345678 00000000
R 00000004 00000000 00000000
R 0000000c 00000000 00000000
W 00005000 deadbeef 00000000
R 00005000 00000000 00000000
W 00000000 00000003 00000000
P 00000000 00000000 00000006
I 00000000 00000000 00000001
W 00002004 00000002 00000000
I 00000000 00000000 00000000
W 00002004 00000003 00000000
I 00000000 00000000 00000001
W 00000000 00000006 00000000
R 00000000 00000000 00000002
I 00000000 00000000 00000000
W 00001000 00000003 00000000
P 00001000 00000000 00000006
R 00002000 00000000 00000002
I 00000000 00000000 00000001
W 00000000 00000001 00000000
P 00000000 00000000 00000004
R 00002000 00000000 00000002
W 00001000 00000004 00000000
R 00002000 00000000 00000000
I 00000000 00000000 00000000

//--- tb/tb_clock_gen.sv
// clock and synchronous reset source for the peripheral testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // 100 ns period
    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    // reset held low over the first two rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire
